// File: build.f
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_execute.sv
rtl/store_writeback.sv
rtl/core_top.sv
tests/core_properties.sv
tests/core_tb.sv

// File: rtl/core_defines.svh
////////////////////////////////////////////////////////////////////////////
// Width, opcode and funct code macros for the small RV32I pipeline
// Included by the package and by any module that decodes instructions
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath and register file sizes
`define CORE_XLEN      32
`define CORE_NUM_REGS  32
`define CORE_REG_AW    5

// Major opcodes of the kept instructions
`define CORE_OPC_LUI   7'b0110111
`define CORE_OPC_OPIMM 7'b0010011
`define CORE_OPC_OP    7'b0110011
`define CORE_OPC_STORE 7'b0100011

// funct3 codes, ALU ops reuse these directly
`define CORE_F3_ADD    3'b000
`define CORE_F3_XOR    3'b100
`define CORE_F3_OR     3'b110
`define CORE_F3_AND    3'b111
`define CORE_F3_SW     3'b010

// Bit index inside funct7 that turns ADD into SUB
`define CORE_F7_SUB    5

`endif

// File: rtl/core_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the pipeline: meaningful vector widths, the fetch FSM
// states and the structs passed between stages and onto the data bus
// Referenced by scoped name from every RTL file
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_defines.svh"

package core_pkg;

  // Plain vectors with a meaning
  typedef logic [`CORE_XLEN-1:0]   word_t;
  typedef logic [`CORE_XLEN-1:0]   addr_t;
  typedef logic [`CORE_XLEN-1:0]   instr_t;
  typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

  // Same encoding as funct3, SUB flagged separately
  typedef logic [2:0] alu_op_t;

  // Instruction fetch FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  // Decode/execute result handed to writeback
  typedef struct packed {
    word_t     result;
    reg_addr_t rd;
    logic      rf_we;
    logic      is_store;
    addr_t     store_addr;
    word_t     store_data;
  } ex_wb_t;

  // Store request payload, always a full word
  typedef struct packed {
    addr_t addr;
    word_t wdata;
  } dbus_req_t;

endpackage

`default_nettype wire

// File: rtl/core_top.sv
////////////////////////////////////////////////////////////////////////////
// Core top level, connects fetch, decode/execute, the register file and
// writeback to the instruction and data buses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_top (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              fetch_enable_i,
  input  core_pkg::addr_t   boot_addr_i,
  // Instruction bus
  output logic              instr_req_o,
  output core_pkg::addr_t   instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  core_pkg::instr_t  instr_rdata_i,
  // Data bus, stores only
  output logic              data_req_o,
  output core_pkg::addr_t   data_addr_o,
  output core_pkg::word_t   data_wdata_o,
  input  logic              data_gnt_i
);

  logic                if_valid;
  core_pkg::instr_t    if_instr;
  logic                id_ready;
  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::word_t     rs1_data;
  core_pkg::word_t     rs2_data;
  logic                ex_valid;
  core_pkg::ex_wb_t    ex_wb;
  logic                wb_ready;
  logic                rf_we;
  core_pkg::reg_addr_t rf_waddr;
  core_pkg::word_t     rf_wdata;
  core_pkg::dbus_req_t dbus_req;

  fetch_stage u_fetch_stage (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_valid_o     ( if_valid       ),
    .if_instr_o     ( if_instr       ),
    .id_ready_i     ( id_ready       )
  );

  // Writeback port doubles as the forwarding source
  decode_execute u_decode_execute (
    .clk_i      ( clk_i    ),
    .rst_i      ( rst_i    ),
    .if_valid_i ( if_valid ),
    .if_instr_i ( if_instr ),
    .id_ready_o ( id_ready ),
    .rs1_addr_o ( rs1_addr ),
    .rs2_addr_o ( rs2_addr ),
    .rs1_data_i ( rs1_data ),
    .rs2_data_i ( rs2_data ),
    .fwd_we_i   ( rf_we    ),
    .fwd_addr_i ( rf_waddr ),
    .fwd_data_i ( rf_wdata ),
    .ex_valid_o ( ex_valid ),
    .ex_wb_o    ( ex_wb    ),
    .wb_ready_i ( wb_ready )
  );

  register_file u_register_file (
    .clk_i     ( clk_i    ),
    .rst_i     ( rst_i    ),
    .raddr_a_i ( rs1_addr ),
    .rdata_a_o ( rs1_data ),
    .raddr_b_i ( rs2_addr ),
    .rdata_b_o ( rs2_data ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata )
  );

  store_writeback u_store_writeback (
    .clk_i              ( clk_i      ),
    .rst_i              ( rst_i      ),
    .ex_valid_i         ( ex_valid   ),
    .ex_wb_i            ( ex_wb      ),
    .wb_ready_o         ( wb_ready   ),
    .rf_we_o            ( rf_we      ),
    .rf_waddr_o         ( rf_waddr   ),
    .rf_wdata_o         ( rf_wdata   ),
    .data_req_o         ( data_req_o ),
    .data_req_payload_o ( dbus_req   ),
    .data_gnt_i         ( data_gnt_i )
  );

  // Payload struct out to the flat bus ports
  assign data_addr_o  = dbus_req.addr;
  assign data_wdata_o = dbus_req.wdata;

endmodule

`default_nettype wire

// File: rtl/decode_execute.sv
////////////////////////////////////////////////////////////////////////////
// Decode and execute for LUI, OP-IMM, OP and SW
// Reads operands with forwarding, computes the ALU result or store
// address and registers one ex_wb_t entry toward writeback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_execute (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 if_valid_i,
  input  core_pkg::instr_t     if_instr_i,
  output logic                 id_ready_o,
  output core_pkg::reg_addr_t  rs1_addr_o,
  output core_pkg::reg_addr_t  rs2_addr_o,
  input  core_pkg::word_t      rs1_data_i,
  input  core_pkg::word_t      rs2_data_i,
  input  logic                 fwd_we_i,
  input  core_pkg::reg_addr_t  fwd_addr_i,
  input  core_pkg::word_t      fwd_data_i,
  output logic                 ex_valid_o,
  output core_pkg::ex_wb_t     ex_wb_o,
  input  logic                 wb_ready_i
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::reg_addr_t rd;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  core_pkg::word_t     imm_i;
  core_pkg::word_t     imm_u;
  core_pkg::word_t     imm_s;
  logic                is_lui;
  logic                is_opimm;
  logic                is_op;
  logic                is_sw;
  logic                f3_ok;
  logic                f7_ok;
  core_pkg::word_t     rs1_val;
  core_pkg::word_t     rs2_val;
  core_pkg::word_t     op_b;
  core_pkg::alu_op_t   alu_op;
  logic                alu_sub;
  core_pkg::word_t     alu_res;
  core_pkg::ex_wb_t    ex_d;
  core_pkg::ex_wb_t    ex_q;
  logic                ex_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Field split and immediates

  assign opcode = if_instr_i[6:0];
  assign rd     = if_instr_i[11:7];
  assign funct3 = if_instr_i[14:12];
  assign rs1    = if_instr_i[19:15];
  assign rs2    = if_instr_i[24:20];
  assign funct7 = if_instr_i[31:25];

  // I, U and S formats
  assign imm_i = {{20{if_instr_i[31]}}, if_instr_i[31:20]};
  assign imm_u = {if_instr_i[31:12], 12'b0};
  assign imm_s = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};

  assign is_lui   = (opcode == `CORE_OPC_LUI);
  assign is_opimm = (opcode == `CORE_OPC_OPIMM);
  assign is_op    = (opcode == `CORE_OPC_OP);
  assign is_sw    = (opcode == `CORE_OPC_STORE) && (funct3 == `CORE_F3_SW);

  // Only ADD/XOR/OR/AND kinds, shifts and compares fall out as no-ops
  assign f3_ok = (funct3 == `CORE_F3_ADD) || (funct3 == `CORE_F3_XOR) ||
                 (funct3 == `CORE_F3_OR)  || (funct3 == `CORE_F3_AND);
  // Register form allows funct7 zero, or the SUB pattern on ADD
  assign f7_ok = (funct7 == 7'b0) ||
                 ((funct7 == (7'b1 << `CORE_F7_SUB)) && (funct3 == `CORE_F3_ADD));

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding

  // Youngest producer first, own output register, then writeback
  always_comb begin
    if (ex_valid_q && ex_q.rf_we && (ex_q.rd != '0) && (ex_q.rd == rs1)) begin
      rs1_val = ex_q.result;
    end else if (fwd_we_i && (fwd_addr_i != '0) && (fwd_addr_i == rs1)) begin
      rs1_val = fwd_data_i;
    end else begin
      rs1_val = rs1_data_i;
    end
    if (ex_valid_q && ex_q.rf_we && (ex_q.rd != '0) && (ex_q.rd == rs2)) begin
      rs2_val = ex_q.result;
    end else if (fwd_we_i && (fwd_addr_i != '0) && (fwd_addr_i == rs2)) begin
      rs2_val = fwd_data_i;
    end else begin
      rs2_val = rs2_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU

  assign alu_op  = core_pkg::alu_op_t'(funct3);
  assign alu_sub = is_op && funct7[`CORE_F7_SUB];
  assign op_b    = is_opimm ? imm_i : rs2_val;

  always_comb begin
    case (alu_op)
      `CORE_F3_ADD: alu_res = alu_sub ? (rs1_val - op_b) : (rs1_val + op_b);
      `CORE_F3_XOR: alu_res = rs1_val ^ op_b;
      `CORE_F3_OR:  alu_res = rs1_val | op_b;
      `CORE_F3_AND: alu_res = rs1_val & op_b;
      default:      alu_res = '0;
    endcase
  end

  // Unknown encodings carry neither write nor store
  always_comb begin
    ex_d.result     = is_lui ? imm_u : alu_res;
    ex_d.rd         = rd;
    ex_d.rf_we      = is_lui || (is_opimm && f3_ok) || (is_op && f3_ok && f7_ok);
    ex_d.is_store   = is_sw;
    ex_d.store_addr = rs1_val + imm_s;
    ex_d.store_data = rs2_val;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register toward writeback

  assign id_ready_o = !ex_valid_q || wb_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid_q <= 1'b0;
    end else if (id_ready_o) begin
      ex_valid_q <= if_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_ready_o && if_valid_i) begin
      ex_q <= ex_d;
    end
  end

  assign ex_valid_o = ex_valid_q;
  assign ex_wb_o    = ex_q;

endmodule

`default_nettype wire

// File: rtl/fetch_stage.sv
////////////////////////////////////////////////////////////////////////////
// Instruction fetch over the req/gnt/rvalid instruction bus
// Fetches sequential words from the boot address once enabled and keeps
// one instruction in a buffer until decode takes it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              fetch_enable_i,
  input  core_pkg::addr_t   boot_addr_i,
  output logic              instr_req_o,
  output core_pkg::addr_t   instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  core_pkg::instr_t  instr_rdata_i,
  output logic              if_valid_o,
  output core_pkg::instr_t  if_instr_o,
  input  logic              id_ready_i
);

  core_pkg::fetch_state_e state_q;
  core_pkg::fetch_state_e state_d;
  core_pkg::addr_t        pc_q;
  logic                   enabled_q;
  logic                   run;
  logic                   buf_free;
  logic                   resp;
  logic                   buf_valid_q;
  core_pkg::instr_t       buf_instr_q;

  // Enable is sticky once seen
  assign run      = enabled_q || fetch_enable_i;
  // Buffer empty now, or decode takes it this cycle
  assign buf_free = !buf_valid_q || id_ready_i;
  assign resp     = (state_q == core_pkg::FETCH_WAIT) && instr_rvalid_i;

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::FETCH_IDLE: begin
        // Only one word may be in the buffer or in flight
        if (run && buf_free) begin
          state_d = core_pkg::FETCH_REQ;
        end
      end
      core_pkg::FETCH_REQ: begin
        if (instr_gnt_i) begin
          state_d = core_pkg::FETCH_WAIT;
        end
      end
      core_pkg::FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = core_pkg::FETCH_IDLE;
        end
      end
      default: state_d = core_pkg::FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= core_pkg::FETCH_IDLE;
      enabled_q <= 1'b0;
      pc_q      <= boot_addr_i;
    end else begin
      state_q <= state_d;
      if (fetch_enable_i) begin
        enabled_q <= 1'b1;
      end
      // PC tracks boot address until fetch runs, then steps per grant
      if (!enabled_q) begin
        pc_q <= boot_addr_i;
      end else if (instr_req_o && instr_gnt_i) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  // Address comes straight from the PC, stable until grant
  assign instr_req_o  = (state_q == core_pkg::FETCH_REQ);
  assign instr_addr_o = pc_q;

  ////////////////////////////////////////////////////////////////////////////
  // One-entry buffer toward decode

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_valid_q <= 1'b0;
    end else if (resp) begin
      buf_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp) begin
      buf_instr_q <= instr_rdata_i;
    end
  end

  assign if_valid_o = buf_valid_q;
  assign if_instr_o = buf_instr_q;

endmodule

`default_nettype wire

// File: rtl/register_file.sv
////////////////////////////////////////////////////////////////////////////
// Integer register file, two combinational read ports and one write port
// x0 is never written and always reads as zero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  core_pkg::reg_addr_t  raddr_a_i,
  output core_pkg::word_t      rdata_a_o,
  input  core_pkg::reg_addr_t  raddr_b_i,
  output core_pkg::word_t      rdata_b_o,
  input  logic                 we_i,
  input  core_pkg::reg_addr_t  waddr_i,
  input  core_pkg::word_t      wdata_i
);

  core_pkg::word_t regs [`CORE_NUM_REGS];

  // Entry 0 is skipped by the write loop and stays at its reset value
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      if (rst_i) begin
        regs[i] <= '0;
      end else if (we_i && (i != 0) && (waddr_i == core_pkg::reg_addr_t'(i))) begin
        regs[i] <= wdata_i;
      end
    end
  end

  // Asynchronous reads
  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// File: rtl/store_writeback.sv
////////////////////////////////////////////////////////////////////////////
// Writeback and store stage, holds one entry from decode/execute
// Results go to the register file in one cycle, stores wait on the
// data bus grant before the entry is released
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module store_writeback (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 ex_valid_i,
  input  core_pkg::ex_wb_t     ex_wb_i,
  output logic                 wb_ready_o,
  output logic                 rf_we_o,
  output core_pkg::reg_addr_t  rf_waddr_o,
  output core_pkg::word_t      rf_wdata_o,
  output logic                 data_req_o,
  output core_pkg::dbus_req_t  data_req_payload_o,
  input  logic                 data_gnt_i
);

  core_pkg::ex_wb_t wb_q;
  logic             wb_valid_q;
  logic             wb_done;

  // Non-stores finish in their first cycle, stores on grant
  assign wb_done    = wb_valid_q && (!wb_q.is_store || data_gnt_i);
  assign wb_ready_o = !wb_valid_q || wb_done;

  ////////////////////////////////////////////////////////////////////////////
  // Entry register

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid_q <= 1'b0;
    end else if (wb_ready_o) begin
      wb_valid_q <= ex_valid_i;
    end
  end

  // Payload only loads on accept, so it is stable across a stall
  always_ff @(posedge clk_i) begin
    if (ex_valid_i && wb_ready_o) begin
      wb_q <= ex_wb_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file write

  // Entry lives one cycle, so exactly one write per result
  assign rf_we_o    = wb_valid_q && wb_q.rf_we;
  assign rf_waddr_o = wb_q.rd;
  assign rf_wdata_o = wb_q.result;

  ////////////////////////////////////////////////////////////////////////////
  // Data bus request

  // Store done at grant, no response phase
  assign data_req_o               = wb_valid_q && wb_q.is_store;
  assign data_req_payload_o.addr  = wb_q.store_addr;
  assign data_req_payload_o.wdata = wb_q.store_data;

endmodule

`default_nettype wire

// File: tests/core_properties.sv
////////////////////////////////////////////////////////////////////////////
// Bus protocol and reset assertions for the core, bound into core_top
// Counts failures so the testbench can see them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_properties (
  input logic            clk_i,
  input logic            rst_i,
  input logic            instr_req_i,
  input core_pkg::addr_t instr_addr_i,
  input logic            instr_gnt_i,
  input logic            instr_rvalid_i,
  input logic            data_req_i,
  input core_pkg::addr_t data_addr_i,
  input core_pkg::word_t data_wdata_i,
  input logic            data_gnt_i,
  input logic            if_valid_i,
  input logic            ex_valid_i
);

  int   error_count = 0;
  logic fetch_busy_q;

  // One fetch in flight between grant and rvalid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_busy_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i) begin
      fetch_busy_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      fetch_busy_q <= 1'b0;
    end
  end

  instr_addr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
    else begin
      error_count++;
      $error("instruction request dropped or address changed before grant");
    end

  one_fetch_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    fetch_busy_q |-> !instr_req_i)
    else begin
      error_count++;
      $error("new instruction request before rvalid of the previous one");
    end

  data_payload_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    data_req_i && !data_gnt_i |=> data_req_i && $stable(data_addr_i) && $stable(data_wdata_i))
    else begin
      error_count++;
      $error("store dropped or payload changed before grant");
    end

  // Pipeline empty and both buses idle right after reset
  reset_idle: assert property (@(posedge clk_i)
    rst_i |=> !instr_req_i && !data_req_i && !if_valid_i && !ex_valid_i)
    else begin
      error_count++;
      $error("pipeline or bus active after reset");
    end

endmodule

bind core_top core_properties u_core_properties (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .instr_req_i    ( instr_req_o    ),
  .instr_addr_i   ( instr_addr_o   ),
  .instr_gnt_i    ( instr_gnt_i    ),
  .instr_rvalid_i ( instr_rvalid_i ),
  .data_req_i     ( data_req_o     ),
  .data_addr_i    ( data_addr_o    ),
  .data_wdata_i   ( data_wdata_o   ),
  .data_gnt_i     ( data_gnt_i     ),
  .if_valid_i     ( if_valid       ),
  .ex_valid_i     ( ex_valid       )
);

`default_nettype wire

// File: tests/core_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the pipeline core. Runs a random program, builds expected
// stores with a reference model, and stalls both buses at random. Every
// granted store is checked in program order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_tb;

  localparam int          NUM_INSTR  = 150;
  localparam int          NUM_DUMP   = 8;
  localparam int          MAX_CYCLES = 4000;
  localparam logic [31:0] BOOT_ADDR  = 32'h0000_0400;
  // addi x0, x0, 0 past the end of the program
  localparam logic [31:0] NOP        = 32'h0000_0013;

  logic                clk_i;
  logic                rst_i;
  logic                fetch_enable_i;
  core_pkg::addr_t     boot_addr_i;
  logic                instr_req_o;
  core_pkg::addr_t     instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  core_pkg::instr_t    instr_rdata_i;
  logic                data_req_o;
  core_pkg::addr_t     data_addr_o;
  core_pkg::word_t     data_wdata_o;
  logic                data_gnt_i;

  core_pkg::instr_t    imem [NUM_INSTR];
  core_pkg::word_t     model_regs [`CORE_NUM_REGS];
  core_pkg::dbus_req_t exp_stores [$];
  core_pkg::dbus_req_t exp_st;
  integer              seed;
  int                  cycles = 0;
  int                  stores_seen;
  int                  igrant_wait;
  int                  rvalid_wait;
  int                  dgrant_wait;
  logic                rsp_pending;
  core_pkg::addr_t     rsp_addr;
  logic                fetched_any;
  core_pkg::addr_t     last_fetch;

  core_top u_core_top (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting

  task automatic flag_mismatch(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("Error %s: expected %08h, actual %08h", test, exp, act);
    $display("*** FAILED ***");
    $fatal(1, "%s mismatch", test);
  endtask

  task automatic abort_run(input string what);
    $display("Run stopped: %s", what);
    $display("*** FAILED ***");
    $fatal(1, "%s", what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // RV32I encodings and reference ALU

  function automatic core_pkg::instr_t r_format(input logic [6:0] f7, input logic [2:0] f3,
      input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, `CORE_OPC_OP};
  endfunction

  function automatic core_pkg::instr_t i_format(input logic [2:0] f3, input logic [4:0] rd,
      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, `CORE_OPC_OPIMM};
  endfunction

  function automatic core_pkg::instr_t s_format(input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, `CORE_F3_SW, imm[4:0], `CORE_OPC_STORE};
  endfunction

  function automatic core_pkg::instr_t u_format(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, `CORE_OPC_LUI};
  endfunction

  function automatic core_pkg::word_t expected_alu(input logic [2:0] f3, input logic sub,
      input core_pkg::word_t a, input core_pkg::word_t b);
    case (f3)
      `CORE_F3_XOR: return a ^ b;
      `CORE_F3_OR:  return a | b;
      `CORE_F3_AND: return a & b;
      default:      return sub ? (a - b) : (a + b);
    endcase
  endfunction

  // Word at a byte address or NOP outside the program
  function automatic core_pkg::instr_t fetch_word(input core_pkg::addr_t addr);
    core_pkg::addr_t offs;
    offs = (addr - BOOT_ADDR) >> 2;
    if (offs < NUM_INSTR) begin
      return imem[offs];
    end else begin
      return NOP;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Program generator and reference model

  task automatic build_program();
    int                  kind;
    int                  sel;
    int                  i;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          prev_rd;
    logic [11:0]         imm;
    logic [19:0]         upper;
    logic [2:0]          f3;
    logic                sub;
    core_pkg::word_t     a;
    core_pkg::word_t     b;
    core_pkg::word_t     res;
    core_pkg::dbus_req_t st;
    prev_rd = 5'd1;
    res     = '0;
    for (i = 0; i < `CORE_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    for (i = 0; i < NUM_INSTR; i++) begin
      // Registers x0..x7 only and half the sources reuse the last result
      rd    = 5'($unsigned($random(seed)) % 8);
      rs1   = (($random(seed) & 1) != 0) ? prev_rd : 5'($unsigned($random(seed)) % 8);
      rs2   = (($random(seed) & 1) != 0) ? prev_rd : 5'($unsigned($random(seed)) % 8);
      imm   = 12'($random(seed));
      upper = 20'($random(seed));
      sel   = $unsigned($random(seed)) % 5;
      kind  = $unsigned($random(seed)) % 16;
      // Tail of the program stores x0..x7 to low addresses
      if (i >= NUM_INSTR - NUM_DUMP) begin
        kind = 11;
        rs1  = 5'd0;
        rs2  = 5'(i - (NUM_INSTR - NUM_DUMP));
        imm  = {5'b0, rs2, 2'b00};
      end
      case (sel)
        1:       f3 = `CORE_F3_XOR;
        2:       f3 = `CORE_F3_OR;
        3:       f3 = `CORE_F3_AND;
        default: f3 = `CORE_F3_ADD;
      endcase
      sub = (sel == 4);
      a   = model_regs[rs1];
      b   = model_regs[rs2];
      if (kind < 2) begin
        imem[i] = u_format(rd, upper);
        res     = {upper, 12'b0};
      end else if (kind < 6) begin
        imem[i] = i_format(f3, rd, rs1, imm);
        res     = expected_alu(f3, 1'b0, a, {{20{imm[11]}}, imm});
      end else if (kind < 11) begin
        imem[i] = r_format(sub ? 7'h20 : 7'h00, f3, rd, rs1, rs2);
        res     = expected_alu(f3, sub, a, b);
      end else if (kind < 14) begin
        imem[i]  = s_format(rs1, rs2, imm);
        st.addr  = a + {{20{imm[11]}}, imm};
        st.wdata = b;
        exp_stores.push_back(st);
      end else if (kind == 14) begin
        // SLTI or SLTIU is not supported
        imem[i] = i_format({2'b01, sel[0]}, rd, rs1, imm);
      end else begin
        // M extension encoding is not supported
        imem[i] = r_format(7'h01, f3, rd, rs1, rs2);
      end
      if (kind < 11) begin
        if (rd != 5'd0) begin
          model_regs[rd] = res;
        end
        prev_rd = rd;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus responders and checks on the falling edge

  always @(negedge clk_i) begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    data_gnt_i     = 1'b0;
    if (rst_i) begin
      rsp_pending = 1'b0;
    end else begin
      assert (u_core_top.u_core_properties.error_count == 0)
        else abort_run("bound protocol assertion failed");
      if (!fetch_enable_i) begin
        assert (!instr_req_o && !data_req_o)
          else abort_run("bus request while fetch is disabled");
      end
      // Response to a grant from an earlier edge
      if (rsp_pending) begin
        if (rvalid_wait == 0) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = fetch_word(rsp_addr);
          rsp_pending    = 1'b0;
        end else begin
          rvalid_wait--;
        end
      end
      if (instr_req_o) begin
        if (igrant_wait == 0) begin
          instr_gnt_i = 1'b1;
          if (fetched_any) begin
            assert (instr_addr_o == last_fetch + 32'd4)
              else flag_mismatch("sequential_fetch", last_fetch + 32'd4, instr_addr_o);
          end else begin
            assert (instr_addr_o == BOOT_ADDR)
              else flag_mismatch("first_fetch", BOOT_ADDR, instr_addr_o);
          end
          fetched_any = 1'b1;
          last_fetch  = instr_addr_o;
          rsp_pending = 1'b1;
          rsp_addr    = instr_addr_o;
          rvalid_wait = $unsigned($random(seed)) % 4;
          igrant_wait = $unsigned($random(seed)) % 4;
        end else begin
          igrant_wait--;
        end
      end
      if (data_req_o) begin
        if (dgrant_wait == 0) begin
          data_gnt_i = 1'b1;
          assert (exp_stores.size() > 0)
            else abort_run("store granted after the last expected store");
          exp_st = exp_stores.pop_front();
          assert (data_addr_o == exp_st.addr)
            else flag_mismatch($sformatf("store_%0d_addr", stores_seen), exp_st.addr,
                               data_addr_o);
          assert (data_wdata_o == exp_st.wdata)
            else flag_mismatch($sformatf("store_%0d_data", stores_seen), exp_st.wdata,
                               data_wdata_o);
          stores_seen++;
          dgrant_wait = $unsigned($random(seed)) % 4;
        end else begin
          dgrant_wait--;
        end
      end
    end
  end

  // Limit covers 150 instructions at about 11 cycles each plus margin
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed           = 32'h35685dcf;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    rsp_pending    = 1'b0;
    rsp_addr       = '0;
    fetched_any    = 1'b0;
    last_fetch     = '0;
    stores_seen    = 0;
    igrant_wait    = 0;
    rvalid_wait    = 0;
    dgrant_wait    = 0;
    build_program();
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // Hold fetch off to see both buses stay idle
    repeat (10) @(negedge clk_i);
    fetch_enable_i = 1'b1;
    while (exp_stores.size() != 0) begin
      @(negedge clk_i);
    end
    // Extra stores during the drain trip the queue check
    repeat (20) @(negedge clk_i);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
